/* hw/rx_pkg.sv */
package rx_pkg;

   // Lane geometry.
   localparam int unsigned num_lanes  = 4;
   localparam int unsigned word_width = 10;

   // Alignment tuning.
   localparam int unsigned lock_count     = 4;
   localparam int unsigned settle_words   = 2;
   localparam int unsigned slip_cnt_width = 4;

   // Counter widths derived from the sizes above.
   localparam int unsigned bit_cnt_width    = $clog2(word_width);
   localparam int unsigned match_cnt_width  = $clog2(lock_count + 1);
   localparam int unsigned settle_cnt_width = $clog2(settle_words + 1);

   // Register map.
   localparam int unsigned addr_width = 2;

   localparam logic [addr_width-1:0] reg_ctrl   = 2'd0;
   localparam logic [addr_width-1:0] reg_train  = 2'd1;
   localparam logic [addr_width-1:0] reg_status = 2'd2;
   localparam logic [addr_width-1:0] reg_slips  = 2'd3;

   // Comma-like pattern, no rotation of it matches itself.
   localparam logic [word_width-1:0] train_reset = 10'h17c;

   // One deserialized word with its strobe.
   typedef struct packed {
      logic                  valid;
      logic [word_width-1:0] data;
   } lane_word_t;

   typedef enum logic [1:0] {
      idle,
      hunt,
      settle,
      locked
   } align_state_t;

endpackage

/* hw/lvds_deser.sv */
module lvds_deser (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               serial_in,
   input  logic               slip,
   output rx_pkg::lane_word_t word
);
   import rx_pkg::*;

   logic [word_width-1:0]    shift_q;
   logic [bit_cnt_width-1:0] bit_cnt;
   logic                     wrap;
   logic                     word_done;
   logic                     valid_q;
   logic [word_width-1:0]    data_q;

   // Last sample of the current word, held off by a slip.
   assign wrap = (bit_cnt == bit_cnt_width'(word_width - 1)) && !slip;

   // LSB-first: the oldest sample drifts down to bit 0.
   always_ff @(posedge clk) begin
      shift_q <= {serial_in, shift_q[word_width-1:1]};
   end

   // Bit counter.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_cnt   <= '0;
         word_done <= 1'b0;
      end else begin
         word_done <= wrap;
         if (wrap) begin
            bit_cnt <= '0;
         end else if (!slip) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // Strobe for one cycle per word.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= word_done;
      end
   end

   // Capture the full word the cycle after its last sample.
   always_ff @(posedge clk) begin
      if (word_done) begin
         data_q <= shift_q;
      end
   end

   assign word = '{valid: valid_q, data: data_q};

endmodule

/* hw/lane_aligner.sv */
module lane_aligner (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start,
   input  logic [rx_pkg::word_width-1:0] train_word,
   input  rx_pkg::lane_word_t            word,
   output logic                          slip,
   output rx_pkg::align_state_t          state
);
   import rx_pkg::*;

   logic [match_cnt_width-1:0]  match_cnt;
   logic [settle_cnt_width-1:0] settle_cnt;
   logic                        word_match;
   logic                        last_match;
   logic                        last_settle;

   assign word_match  = (word.data == train_word);
   assign last_match  = (match_cnt == match_cnt_width'(lock_count - 1));
   assign last_settle = (settle_cnt == settle_cnt_width'(settle_words - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= idle;
         match_cnt  <= '0;
         settle_cnt <= '0;
         slip       <= 1'b0;
      end else begin
         slip <= 1'b0;
         if (start) begin
            // Restart from any state.
            state      <= hunt;
            match_cnt  <= '0;
            settle_cnt <= '0;
         end else if (word.valid) begin
            case (state)
               hunt: begin
                  if (word_match) begin
                     match_cnt <= match_cnt + 1'b1;
                     if (last_match) begin
                        state <= locked;
                     end
                  end else begin
                     // Move the boundary one bit and let it settle.
                     match_cnt  <= '0;
                     settle_cnt <= '0;
                     slip       <= 1'b1;
                     state      <= settle;
                  end
               end
               settle: begin
                  if (last_settle) begin
                     state <= hunt;
                  end else begin
                     settle_cnt <= settle_cnt + 1'b1;
                  end
               end
               default: begin
                  // Idle waits for start, locked holds.
                  state <= state;
               end
            endcase
         end
      end
   end

endmodule

/* hw/rx_ctrl_regs.sv */
module rx_ctrl_regs (
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         wr_en,
   input  logic [rx_pkg::addr_width-1:0]                addr,
   input  logic [rx_pkg::word_width-1:0]                wr_data,
   output logic [rx_pkg::word_width-1:0]                rd_data,
   input  rx_pkg::align_state_t [rx_pkg::num_lanes-1:0] lane_state,
   input  logic [rx_pkg::num_lanes-1:0]                 lane_slip,
   output logic [rx_pkg::num_lanes-1:0]                 start,
   output logic [rx_pkg::word_width-1:0]                train_word,
   output logic                                         rx_locked
);
   import rx_pkg::*;

   logic [slip_cnt_width-1:0] slip_cnt [num_lanes];
   logic [num_lanes-1:0]      lane_locked;
   logic                      ctrl_wr;
   logic                      train_wr;
   logic                      slips_wr;
   logic                      slips_sel;

   assign ctrl_wr  = wr_en && (addr == reg_ctrl);
   assign train_wr = wr_en && (addr == reg_train);
   assign slips_wr = wr_en && (addr == reg_slips);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         start      <= '0;
         train_word <= train_reset;
         slips_sel  <= 1'b0;
      end else begin
         start <= ctrl_wr ? wr_data[num_lanes-1:0] : '0;
         if (train_wr) begin
            train_word <= wr_data;
         end
         if (slips_wr) begin
            slips_sel <= wr_data[0];
         end
      end
   end

   // Saturating slip counters, cleared again while start is out
   // so a slip already in flight is not counted.
   always_ff @(posedge clk) begin
      for (int i = 0; i < num_lanes; i++) begin
         if (!rst_n) begin
            slip_cnt[i] <= '0;
         end else if ((ctrl_wr && wr_data[i]) || start[i]) begin
            slip_cnt[i] <= '0;
         end else if (lane_slip[i] && (slip_cnt[i] != '1)) begin
            slip_cnt[i] <= slip_cnt[i] + 1'b1;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < num_lanes; i++) begin
         lane_locked[i] = (lane_state[i] == locked);
      end
   end

   assign rx_locked = &lane_locked;

   // Two lanes per slip read.
   always_comb begin
      case (addr)
         reg_train:  rd_data = train_word;
         reg_status: rd_data = word_width'(lane_locked);
         reg_slips:  rd_data = word_width'({slip_cnt[{slips_sel, 1'b1}],
                                            slip_cnt[{slips_sel, 1'b0}]});
         default:    rd_data = '0;
      endcase
   end

endmodule

/* hw/rx_lanes_top.sv */
module rx_lanes_top (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic [rx_pkg::num_lanes-1:0]               serial_in,
   input  logic                                       wr_en,
   input  logic [rx_pkg::addr_width-1:0]              addr,
   input  logic [rx_pkg::word_width-1:0]              wr_data,
   output logic [rx_pkg::word_width-1:0]              rd_data,
   output rx_pkg::lane_word_t [rx_pkg::num_lanes-1:0] lane_words,
   output logic                                       rx_locked
);
   import rx_pkg::*;

   logic [num_lanes-1:0]         lane_slip;
   logic [num_lanes-1:0]         lane_start;
   align_state_t [num_lanes-1:0] lane_state;
   logic [word_width-1:0]        train_word;

   // One deserializer and aligner per lane.
   for (genvar i = 0; i < num_lanes; i++) begin : g_lane
      lvds_deser u_lvds_deser (
         .clk       (clk),
         .rst_n     (rst_n),
         .serial_in (serial_in[i]),
         .slip      (lane_slip[i]),
         .word      (lane_words[i])
      );

      lane_aligner u_lane_aligner (
         .clk        (clk),
         .rst_n      (rst_n),
         .start      (lane_start[i]),
         .train_word (train_word),
         .word       (lane_words[i]),
         .slip       (lane_slip[i]),
         .state      (lane_state[i])
      );
   end

   rx_ctrl_regs u_rx_ctrl_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en      (wr_en),
      .addr       (addr),
      .wr_data    (wr_data),
      .rd_data    (rd_data),
      .lane_state (lane_state),
      .lane_slip  (lane_slip),
      .start      (lane_start),
      .train_word (train_word),
      .rx_locked  (rx_locked)
   );

endmodule

/* sim/rx_tb.sv */
module rx_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import rx_pkg::*;

   localparam int lock_words = num_lanes * (word_width + 1) * (settle_words + 1 + lock_count);
   localparam logic [word_width-1:0] new_train = 10'h283;

   logic                                clk;
   logic                                rst_n;
   logic [num_lanes-1:0]                serial_in;
   logic                                wr_en;
   logic [addr_width-1:0]               addr;
   logic [word_width-1:0]               wr_data;
   logic [word_width-1:0]               rd_data;
   rx_pkg::lane_word_t [num_lanes-1:0]  lane_words;
   logic                                rx_locked;

   int                    errors;
   string                 test_name;
   logic [15:0]           lfsr;
   int                    rst_cnt;
   int                    tx_mode;
   int                    offset [num_lanes];
   int                    pos [num_lanes];
   logic [word_width-1:0] cur [num_lanes];
   logic [num_lanes-1:0]  sent_last;
   logic [word_width-1:0] sent_word [num_lanes];
   logic [num_lanes-1:0]  st1_last;
   logic [num_lanes-1:0]  st2_last;
   logic [word_width-1:0] st1_word [num_lanes];
   logic [word_width-1:0] st2_word [num_lanes];
   int                    gap_cnt [num_lanes];
   int                    gap_at_valid [num_lanes];
   logic                  rd_chk;
   logic [word_width-1:0] exp_rd;
   logic                  lock_chk;
   logic                  exp_locked;
   logic                  reset_chk;
   logic                  data_chk;

   rx_lanes_top u_rx_lanes_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .serial_in  (serial_in),
      .wr_en      (wr_en),
      .addr       (addr),
      .wr_data    (wr_data),
      .rd_data    (rd_data),
      .lane_words (lane_words),
      .rx_locked  (rx_locked)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Galois LFSR, taps 16,14,13,11.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v[k] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Serializer model, LSB-first, one new word per lane at pos 0.
   task automatic drive_serial();
      logic [15:0] v;
      for (int i = 0; i < num_lanes; i++) begin
         if (pos[i] == 0) begin
            if (tx_mode == 1) begin
               take_bits(word_width, v);
               cur[i] = v[word_width-1:0];
            end else if (tx_mode == 2) begin
               cur[i] = new_train;
            end else begin
               cur[i] = train_reset;
            end
         end
         serial_in[i] = cur[i][pos[i]];
         sent_last[i] = (pos[i] == word_width - 1);
         sent_word[i] = cur[i];
         pos[i] = (pos[i] + 1) % word_width;
      end
   endtask

   always @(negedge clk) begin
      if (rst_cnt < 2) begin
         rst_cnt++;
         rst_n = 1'b0;
      end else begin
         rst_n = 1'b1;
         drive_serial();
      end
      for (int i = 0; i < num_lanes; i++) begin
         if (lane_words[i].valid === 1'b1) begin
            gap_at_valid[i] = gap_cnt[i];
            gap_cnt[i] = 1;
         end else begin
            gap_cnt[i]++;
         end
      end
   end

   // A word's last bit shows up as valid two edges later.
   always @(posedge clk) begin
      st1_last <= sent_last;
      st2_last <= st1_last;
      st1_word <= sent_word;
      st2_word <= st1_word;
   end

   a_read: assert property (@(posedge clk) rd_chk |-> rd_data == exp_rd)
      else begin
         errors++;
         $display("Fail %s expected %h actual %h", test_name, exp_rd, rd_data);
      end

   a_lock: assert property (@(posedge clk) lock_chk |-> rx_locked == exp_locked)
      else begin
         errors++;
         $display("Fail %s expected %b actual %b", test_name, exp_locked, rx_locked);
      end

   for (genvar i = 0; i < num_lanes; i++) begin : g_chk
      a_reset_valid: assert property (@(posedge clk)
            reset_chk |-> !lane_words[i].valid)
         else begin
            errors++;
            $display("Lane %0d valid bit set right after reset", i);
         end

      a_word: assert property (@(posedge clk)
            (data_chk && st2_last[i]) |->
            (lane_words[i].valid && lane_words[i].data == st2_word[i]))
         else begin
            errors++;
            $display("Fail %s lane %0d expected %h actual %h", test_name, i,
                     st2_word[i], lane_words[i].data);
         end

      a_gap: assert property (@(posedge clk)
            (data_chk && lane_words[i].valid) |-> gap_at_valid[i] == word_width)
         else begin
            errors++;
            $display("Fail %s lane %0d gap expected %0d actual %0d", test_name, i,
                     word_width, gap_at_valid[i]);
         end
   end

   task automatic reg_write(input logic [addr_width-1:0] a, input logic [word_width-1:0] d);
      @(negedge clk);
      wr_en = 1'b1;
      addr = a;
      wr_data = d;
      @(negedge clk);
      wr_en = 1'b0;
   endtask

   task automatic read_check(input logic [addr_width-1:0] a, input logic [word_width-1:0] e);
      addr = a;
      exp_rd = e;
      rd_chk = 1'b1;
      @(negedge clk);
      rd_chk = 1'b0;
   endtask

   task automatic wait_locked();
      while (rx_locked !== 1'b1) begin
         @(negedge clk);
      end
   endtask

   function automatic logic [word_width-1:0] slip_pair(input int hi, input int lo);
      return word_width'({slip_cnt_width'(hi), slip_cnt_width'(lo)});
   endfunction

   initial begin
      #(8 * lock_words * word_width * 100);
      $display("Watchdog timeout, the run did not finish in time");
      $display("Some tests failed");
      $finish;
   end

   initial begin
      logic [15:0] v;
      rst_n = 1'b0;
      serial_in = '0;
      wr_en = 1'b0;
      addr = '0;
      wr_data = '0;
      errors = 0;
      rst_cnt = 0;
      tx_mode = 0;
      rd_chk = 1'b0;
      lock_chk = 1'b0;
      exp_locked = 1'b0;
      reset_chk = 1'b0;
      data_chk = 1'b0;
      sent_last = '0;
      test_name = "init";
      lfsr = 16'd90;
      for (int i = 0; i < num_lanes; i++) begin
         take_bits(4, v);
         offset[i] = int'(v[3:0]) % word_width;
         pos[i] = (word_width - offset[i]) % word_width;
         cur[i] = train_reset;
         gap_cnt[i] = 0;
         gap_at_valid[i] = 0;
      end

      // Reset state, checked before the first word completes.
      repeat (3) @(negedge clk);
      test_name = "reset";
      lock_chk = 1'b1;
      reset_chk = 1'b1;
      read_check(reg_train, train_reset);
      repeat (3) @(negedge clk);
      lock_chk = 1'b0;
      reset_chk = 1'b0;

      test_name = "align";
      reg_write(reg_ctrl, word_width'(4'hf));
      wait_locked();
      reg_write(reg_slips, '0);
      read_check(reg_slips, slip_pair(offset[1], offset[0]));
      reg_write(reg_slips, word_width'(1));
      read_check(reg_slips, slip_pair(offset[3], offset[2]));

      test_name = "restart";
      reg_write(reg_ctrl, word_width'(4'b0100));
      @(negedge clk);
      exp_locked = 1'b0;
      lock_chk = 1'b1;
      read_check(reg_status, word_width'(4'b1011));
      read_check(reg_slips, slip_pair(offset[3], 0));
      lock_chk = 1'b0;
      wait_locked();
      read_check(reg_status, word_width'(4'hf));
      read_check(reg_slips, slip_pair(offset[3], 0));

      // Lock must hold through random payload.
      test_name = "payload";
      data_chk = 1'b1;
      exp_locked = 1'b1;
      lock_chk = 1'b1;
      tx_mode = 1;
      repeat (40 * word_width) @(negedge clk);
      data_chk = 1'b0;
      lock_chk = 1'b0;

      // Old word on the wire, new word in the register.
      test_name = "train_change";
      tx_mode = 0;
      repeat (3 * word_width) @(negedge clk);
      reg_write(reg_train, new_train);
      reg_write(reg_ctrl, word_width'(4'hf));
      @(negedge clk);
      exp_locked = 1'b0;
      lock_chk = 1'b1;
      repeat (lock_words) @(negedge clk);
      read_check(reg_status, '0);
      read_check(reg_train, new_train);
      lock_chk = 1'b0;
      tx_mode = 2;
      wait_locked();
      read_check(reg_status, word_width'(4'hf));

      repeat (5) @(negedge clk);
      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* filelist.f */
hw/rx_pkg.sv
hw/lvds_deser.sv
hw/lane_aligner.sv
hw/rx_ctrl_regs.sv
hw/rx_lanes_top.sv
sim/rx_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module rx_tb -o rx_sim || exit 1
out=$(./obj_dir/rx_sim)
echo "$out"
echo "$out" | grep -qx "All tests passed" && exit 0 || exit 1
